// File: all.f
logic/mipsPkg.sv
logic/registerFile.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/forwardingUnit.sv
logic/executeStage.sv
logic/retireStage.sv
logic/mipsPipeline.sv
verif/mipsPipelineTb.sv

// File: Makefile
SIM := obj_dir/VmipsPipelineTb
SRCS := $(wildcard logic/*.sv verif/*.sv)

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --assert -f all.f --top-module mipsPipelineTb -o VmipsPipelineTb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: verif/mipsPipelineTb.sv
// Testbench running random MIPS programs on the pipeline against an instruction-level model
`timescale 1ns/1ps

module mipsPipelineTb;

	localparam int imemDepth = 64;
	localparam int progLen = 40;
	localparam int drainLimit = 500;

	// MIPS32 field encodings
	localparam logic [5:0] opR = 6'h00;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnNor = 6'h27;

	logic        clk;
	logic        rstN;
	logic        run;
	logic        progWrite;
	logic [5:0]  progAddr;
	logic [31:0] progData;
	logic        wbValid;
	logic [4:0]  wbReg;
	logic [31:0] wbData;

	logic [31:0] lcgState = 32'd59;
	logic [31:0] prog [imemDepth];
	logic [31:0] model [32];
	// Expected writes, register index above value
	logic [36:0] expected [$];
	logic [36:0] popped;
	int checks = 0;
	int mismatches = 0;
	int failures = 0;

	mipsPipeline #(.imemDepth(imemDepth)) dut (
		.clk(clk), .rstN(rstN), .run(run),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [15:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[31:16];
	endfunction

	// Registers 0 to 7 only, so hazards are dense
	function automatic logic [31:0] randomInstr();
		logic [15:0] r;
		logic [15:0] imm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		int          kind;
		r = nextRand();
		rs = {2'b00, r[2:0]};
		rt = {2'b00, r[5:3]};
		rd = {2'b00, r[8:6]};
		imm = nextRand();
		kind = int'(nextRand() % 16'd12);
		case (kind)
			0: return {opR, rs, rt, rd, 5'h00, fnAdd};
			1: return {opR, rs, rt, rd, 5'h00, fnSub};
			2: return {opR, rs, rt, rd, 5'h00, fnAnd};
			3: return {opR, rs, rt, rd, 5'h00, fnOr};
			4: return {opR, rs, rt, rd, 5'h00, fnNor};
			5, 6: return {opAddi, rs, rt, imm};
			7: return {opOri, rs, rt, imm};
			// Forward offsets 0 to 3
			8: return {opBeq, rs, rt, 14'h0000, imm[1:0]};
			9: return {opBne, rs, rt, 14'h0000, imm[1:0]};
			10: return 32'h0000_0000;
			// slt funct or lw opcode, neither supported
			default: return imm[0] ? {opR, rs, rt, rd, 5'h00, 6'h2a} : {6'h23, rs, rt, imm};
		endcase
	endfunction

	// Tail of the program and the rest of memory are zero words
	task automatic makeProgram();
		for (int i = 0; i < imemDepth; i++) begin
			prog[i] = (i < progLen - 4) ? randomInstr() : 32'h0000_0000;
		end
	endtask

	task automatic recordWrite(input logic [4:0] dest, input logic [31:0] value);
		if (dest != 5'd0) begin
			model[dest] = value;
			expected.push_back({dest, value});
		end
	endtask

	// Interpreter over word indices, register state carries across programs
	task automatic runModel();
		int          pc;
		int          next;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] zext;
		pc = 0;
		while (pc < progLen) begin
			w = prog[pc];
			a = model[w[25:21]];
			b = model[w[20:16]];
			sext = {{16{w[15]}}, w[15:0]};
			zext = {16'h0000, w[15:0]};
			next = pc + 1;
			case (w[31:26])
				opR: begin
					case (w[5:0])
						fnAdd: recordWrite(w[15:11], a + b);
						fnSub: recordWrite(w[15:11], a - b);
						fnAnd: recordWrite(w[15:11], a & b);
						fnOr:  recordWrite(w[15:11], a | b);
						fnNor: recordWrite(w[15:11], ~(a | b));
						default: ;
					endcase
				end
				opAddi: recordWrite(w[20:16], a + sext);
				opOri: recordWrite(w[20:16], a | zext);
				opBeq: if (a == b) next = pc + 1 + int'(sext);
				opBne: if (a != b) next = pc + 1 + int'(sext);
				default: ;
			endcase
			pc = next;
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < imemDepth; i++) begin
			@(negedge clk);
			progWrite = 1'b1;
			progAddr = i[5:0];
			progData = prog[i];
		end
		@(negedge clk);
		progWrite = 1'b0;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			mismatches++;
			$display("** Error: %s is %h, expected %h at %0t", name, got, want, $time);
		end
	endtask

	// Start fetching, wait for every expected write, then watch for strays
	task automatic runProgram(output bit ok);
		int waited;
		ok = 1'b1;
		@(negedge clk);
		run = 1'b1;
		waited = 0;
		while (expected.size() != 0 && waited < drainLimit) begin
			@(posedge clk);
			waited++;
		end
		if (expected.size() != 0) begin
			$display("Timeout: %0d expected writes never retired within %0d cycles",
				expected.size(), drainLimit);
			failures++;
			ok = 1'b0;
		end else begin
			// Monitor flags any strobe in this window
			repeat (20) @(negedge clk);
		end
		@(negedge clk);
		run = 1'b0;
	endtask

	// Outputs change on the rising edge, sampled on the falling one
	always @(negedge clk) begin
		if (rstN && wbValid) begin
			if (expected.size() == 0) begin
				$display("Unexpected writeback to register %0d with no write outstanding at %0t",
					wbReg, $time);
				failures++;
			end else begin
				popped = expected.pop_front();
				checkValue("wbReg", {27'h0, wbReg}, {27'h0, popped[36:32]});
				checkValue("wbData", wbData, popped[31:0]);
			end
		end
	end

	initial begin
		bit ok;
		rstN = 1'b0;
		run = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		for (int i = 0; i < 32; i++) begin
			model[i] = 32'h0000_0000;
		end
		repeat (5) @(negedge clk);
		rstN = 1'b1;
		ok = 1'b1;
		// Second program starts from the register state left by the first
		for (int p = 0; p < 2 && ok; p++) begin
			makeProgram();
			runModel();
			loadProgram();
			runProgram(ok);
		end
		$display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: logic/mipsPipeline.sv
// Five-stage MIPS integer pipeline top joining fetch, decode, execute, retire and forwarding
`timescale 1ns/1ps

module mipsPipeline #(
	parameter int imemDepth = 64,
	localparam int idxWidth = $clog2(imemDepth)
) (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             run,
	input  logic                             progWrite,
	input  logic [idxWidth-1:0]              progAddr,
	input  logic [mipsPkg::dataWidth-1:0]    progData,
	output logic                             wbValid,
	output logic [mipsPkg::regAddrWidth-1:0] wbReg,
	output logic [mipsPkg::dataWidth-1:0]    wbData
);

	// Fetch to decode
	logic                             ifValid;
	logic [mipsPkg::dataWidth-1:0]    ifInstr;
	logic [mipsPkg::dataWidth-1:0]    ifPcPlus4;

	// Decode to execute
	logic                             idValid;
	logic [mipsPkg::dataWidth-1:0]    idRsData;
	logic [mipsPkg::dataWidth-1:0]    idRtData;
	logic [mipsPkg::dataWidth-1:0]    idImm;
	logic [mipsPkg::regAddrWidth-1:0] idRs;
	logic [mipsPkg::regAddrWidth-1:0] idRt;
	logic [mipsPkg::regAddrWidth-1:0] idDest;
	mipsPkg::aluOpT                   idAluOp;
	logic                             idUseImm;
	logic                             idRegWrite;
	logic                             idBranchEq;
	logic                             idBranchNe;
	logic [mipsPkg::dataWidth-1:0]    idPcPlus4;

	// Execute to retire
	logic                             exValid;
	logic [mipsPkg::dataWidth-1:0]    exResult;
	logic                             exZero;
	logic [mipsPkg::dataWidth-1:0]    exBranchTarget;
	logic [mipsPkg::regAddrWidth-1:0] exDest;
	logic                             exRegWrite;
	logic                             exBranchEq;
	logic                             exBranchNe;

	// Forward selects and branch redirect
	logic [1:0]                       forwardA;
	logic [1:0]                       forwardB;
	logic                             redirect;
	logic [mipsPkg::dataWidth-1:0]    redirectTarget;

	fetchStage #(.imemDepth(imemDepth)) fetch (
		.clk(clk), .rstN(rstN), .run(run),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.redirect(redirect), .redirectTarget(redirectTarget),
		.ifValid(ifValid), .ifInstr(ifInstr), .ifPcPlus4(ifPcPlus4)
	);

	decodeStage decode (
		.clk(clk), .rstN(rstN), .flush(redirect),
		.ifValid(ifValid), .ifInstr(ifInstr), .ifPcPlus4(ifPcPlus4),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.idValid(idValid), .idRsData(idRsData), .idRtData(idRtData), .idImm(idImm),
		.idRs(idRs), .idRt(idRt), .idDest(idDest), .idAluOp(idAluOp),
		.idUseImm(idUseImm), .idRegWrite(idRegWrite),
		.idBranchEq(idBranchEq), .idBranchNe(idBranchNe), .idPcPlus4(idPcPlus4)
	);

	forwardingUnit forward (
		.idRs(idRs), .idRt(idRt),
		.exDest(exDest), .exRegWrite(exRegWrite), .exValid(exValid),
		.wbReg(wbReg), .wbValid(wbValid),
		.forwardA(forwardA), .forwardB(forwardB)
	);

	executeStage execute (
		.clk(clk), .rstN(rstN), .flush(redirect),
		.idValid(idValid), .idRsData(idRsData), .idRtData(idRtData), .idImm(idImm),
		.idDest(idDest), .idAluOp(idAluOp), .idUseImm(idUseImm),
		.idRegWrite(idRegWrite), .idBranchEq(idBranchEq), .idBranchNe(idBranchNe),
		.idPcPlus4(idPcPlus4), .forwardA(forwardA), .forwardB(forwardB),
		.wbData(wbData),
		.exValid(exValid), .exResult(exResult), .exZero(exZero),
		.exBranchTarget(exBranchTarget), .exDest(exDest), .exRegWrite(exRegWrite),
		.exBranchEq(exBranchEq), .exBranchNe(exBranchNe)
	);

	retireStage retire (
		.clk(clk), .rstN(rstN),
		.exValid(exValid), .exResult(exResult), .exZero(exZero),
		.exBranchTarget(exBranchTarget), .exDest(exDest), .exRegWrite(exRegWrite),
		.exBranchEq(exBranchEq), .exBranchNe(exBranchNe),
		.redirect(redirect), .redirectTarget(redirectTarget),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

endmodule

// File: logic/retireStage.sv
// Retire stage resolving branches and holding the memory/writeback register
`timescale 1ns/1ps

module retireStage (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             exValid,
	input  logic [mipsPkg::dataWidth-1:0]    exResult,
	input  logic                             exZero,
	input  logic [mipsPkg::dataWidth-1:0]    exBranchTarget,
	input  logic [mipsPkg::regAddrWidth-1:0] exDest,
	input  logic                             exRegWrite,
	input  logic                             exBranchEq,
	input  logic                             exBranchNe,
	output logic                             redirect,
	output logic [mipsPkg::dataWidth-1:0]    redirectTarget,
	output logic                             wbValid,
	output logic [mipsPkg::regAddrWidth-1:0] wbReg,
	output logic [mipsPkg::dataWidth-1:0]    wbData
);

	// beq on equal operands, bne on different ones
	assign redirect = exValid && ((exBranchEq && exZero) || (exBranchNe && !exZero));
	assign redirectTarget = exBranchTarget;

	// Strobe only for real writes
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= exValid && exRegWrite && (exDest != '0);
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= exDest;
		wbData <= exResult;
	end

	// Flush of the younger slots rules out a second redirect right after
	singleRedirect: assert property (@(posedge clk) disable iff (!rstN)
		redirect |=> !redirect);

endmodule

// File: logic/executeStage.sv
// Execute stage with forwarding muxes, ALU, branch target and the execute/memory register
`timescale 1ns/1ps

module executeStage (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             flush,
	input  logic                             idValid,
	input  logic [mipsPkg::dataWidth-1:0]    idRsData,
	input  logic [mipsPkg::dataWidth-1:0]    idRtData,
	input  logic [mipsPkg::dataWidth-1:0]    idImm,
	input  logic [mipsPkg::regAddrWidth-1:0] idDest,
	input  mipsPkg::aluOpT                   idAluOp,
	input  logic                             idUseImm,
	input  logic                             idRegWrite,
	input  logic                             idBranchEq,
	input  logic                             idBranchNe,
	input  logic [mipsPkg::dataWidth-1:0]    idPcPlus4,
	input  logic [1:0]                       forwardA,
	input  logic [1:0]                       forwardB,
	input  logic [mipsPkg::dataWidth-1:0]    wbData,
	output logic                             exValid,
	output logic [mipsPkg::dataWidth-1:0]    exResult,
	output logic                             exZero,
	output logic [mipsPkg::dataWidth-1:0]    exBranchTarget,
	output logic [mipsPkg::regAddrWidth-1:0] exDest,
	output logic                             exRegWrite,
	output logic                             exBranchEq,
	output logic                             exBranchNe
);

	logic [mipsPkg::dataWidth-1:0] opA;
	logic [mipsPkg::dataWidth-1:0] opB;
	logic [mipsPkg::dataWidth-1:0] aluB;
	logic [mipsPkg::dataWidth-1:0] aluResult;

	// Memory-stage forward comes straight from our own result register
	assign opA = (forwardA == 2'b10) ? exResult :
		(forwardA == 2'b01) ? wbData : idRsData;
	assign opB = (forwardB == 2'b10) ? exResult :
		(forwardB == 2'b01) ? wbData : idRtData;

	assign aluB = idUseImm ? idImm : opB;

	always_comb begin
		case (idAluOp)
			mipsPkg::aluAdd: aluResult = opA + aluB;
			mipsPkg::aluSub: aluResult = opA - aluB;
			mipsPkg::aluAnd: aluResult = opA & aluB;
			mipsPkg::aluOr:  aluResult = opA | aluB;
			mipsPkg::aluNor: aluResult = ~(opA | aluB);
			default: aluResult = '0;
		endcase
	end

	// Valid and controls
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid <= 1'b0;
			exRegWrite <= 1'b0;
			exBranchEq <= 1'b0;
			exBranchNe <= 1'b0;
		end else begin
			exValid <= idValid && !flush;
			exRegWrite <= idRegWrite;
			exBranchEq <= idBranchEq;
			exBranchNe <= idBranchNe;
		end
	end

	// Result, flag, target
	always_ff @(posedge clk) begin
		exResult <= aluResult;
		exZero <= (aluResult == '0);
		exBranchTarget <= idPcPlus4 + {idImm[mipsPkg::dataWidth-3:0], 2'b00};
		exDest <= idDest;
	end

	// Decode only ever hands over a defined operation
	aluOpKnown: assert property (@(posedge clk) disable iff (!rstN)
		idValid |-> idAluOp inside {mipsPkg::aluAdd, mipsPkg::aluSub,
			mipsPkg::aluAnd, mipsPkg::aluOr, mipsPkg::aluNor});

endmodule

// File: logic/forwardingUnit.sv
// Forwarding unit choosing operand sources from the two later pipeline registers
`timescale 1ns/1ps

module forwardingUnit (
	input  logic [mipsPkg::regAddrWidth-1:0] idRs,
	input  logic [mipsPkg::regAddrWidth-1:0] idRt,
	input  logic [mipsPkg::regAddrWidth-1:0] exDest,
	input  logic                             exRegWrite,
	input  logic                             exValid,
	input  logic [mipsPkg::regAddrWidth-1:0] wbReg,
	input  logic                             wbValid,
	output logic [1:0]                       forwardA,
	output logic [1:0]                       forwardB
);

	logic memWrites;

	// Memory-stage slot about to write a register
	assign memWrites = exValid && exRegWrite;

	// Encoding 2'b10 memory stage, 2'b01 writeback, 2'b00 register file
	// Memory stage holds the newer value so it wins
	always_comb begin
		forwardA = 2'b00;
		if (idRs != '0) begin
			if (memWrites && exDest == idRs) begin
				forwardA = 2'b10;
			end else if (wbValid && wbReg == idRs) begin
				forwardA = 2'b01;
			end
		end
	end

	always_comb begin
		forwardB = 2'b00;
		if (idRt != '0) begin
			if (memWrites && exDest == idRt) begin
				forwardB = 2'b10;
			end else if (wbValid && wbReg == idRt) begin
				forwardB = 2'b01;
			end
		end
	end

endmodule

// File: logic/decodeStage.sv
// Decode stage producing controls, extended immediate and the decode/execute register
`timescale 1ns/1ps

module decodeStage (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             flush,
	input  logic                             ifValid,
	input  logic [mipsPkg::dataWidth-1:0]    ifInstr,
	input  logic [mipsPkg::dataWidth-1:0]    ifPcPlus4,
	input  logic                             wbValid,
	input  logic [mipsPkg::regAddrWidth-1:0] wbReg,
	input  logic [mipsPkg::dataWidth-1:0]    wbData,
	output logic                             idValid,
	output logic [mipsPkg::dataWidth-1:0]    idRsData,
	output logic [mipsPkg::dataWidth-1:0]    idRtData,
	output logic [mipsPkg::dataWidth-1:0]    idImm,
	output logic [mipsPkg::regAddrWidth-1:0] idRs,
	output logic [mipsPkg::regAddrWidth-1:0] idRt,
	output logic [mipsPkg::regAddrWidth-1:0] idDest,
	output mipsPkg::aluOpT                   idAluOp,
	output logic                             idUseImm,
	output logic                             idRegWrite,
	output logic                             idBranchEq,
	output logic                             idBranchNe,
	output logic [mipsPkg::dataWidth-1:0]    idPcPlus4
);

	mipsPkg::opcodeT                  opcode;
	mipsPkg::functT                   funct;
	mipsPkg::aluOpT                   aluOp;
	logic [mipsPkg::regAddrWidth-1:0] rs;
	logic [mipsPkg::regAddrWidth-1:0] rt;
	logic [mipsPkg::regAddrWidth-1:0] dest;
	logic [mipsPkg::dataWidth-1:0]    rsData;
	logic [mipsPkg::dataWidth-1:0]    rtData;
	logic [mipsPkg::dataWidth-1:0]    imm;
	logic                             useImm;
	logic                             regWrite;
	logic                             branchEq;
	logic                             branchNe;

	assign opcode = mipsPkg::opcodeT'(ifInstr[31:26]);
	assign funct = mipsPkg::functT'(ifInstr[5:0]);
	assign rs = ifInstr[25:21];
	assign rt = ifInstr[20:16];

	registerFile regFile (
		.clk(clk),
		.rstN(rstN),
		.rsAddr(rs),
		.rtAddr(rt),
		.writeEnable(wbValid),
		.writeAddr(wbReg),
		.writeData(wbData),
		.rsData(rsData),
		.rtData(rtData)
	);

	// Control decode, anything unlisted stays a bubble
	always_comb begin
		aluOp = mipsPkg::aluAdd;
		useImm = 1'b0;
		regWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		dest = ifInstr[15:11];
		imm = {{16{ifInstr[15]}}, ifInstr[15:0]};
		case (opcode)
			mipsPkg::opRType: begin
				regWrite = 1'b1;
				case (funct)
					mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
					mipsPkg::fnNor: aluOp = mipsPkg::aluNor;
					default: regWrite = 1'b0;
				endcase
			end
			mipsPkg::opAddi: begin
				useImm = 1'b1;
				regWrite = 1'b1;
				dest = rt;
			end
			mipsPkg::opOri: begin
				// Logical immediate is zero-extended
				aluOp = mipsPkg::aluOr;
				useImm = 1'b1;
				regWrite = 1'b1;
				dest = rt;
				imm = {16'h0000, ifInstr[15:0]};
			end
			mipsPkg::opBeq: begin
				aluOp = mipsPkg::aluSub;
				branchEq = 1'b1;
			end
			mipsPkg::opBne: begin
				aluOp = mipsPkg::aluSub;
				branchNe = 1'b1;
			end
			default: ;
		endcase
	end

	// Valid and control half of the decode/execute register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idValid <= 1'b0;
			idAluOp <= mipsPkg::aluAdd;
			idUseImm <= 1'b0;
			idRegWrite <= 1'b0;
			idBranchEq <= 1'b0;
			idBranchNe <= 1'b0;
		end else begin
			idValid <= ifValid && !flush;
			idAluOp <= aluOp;
			idUseImm <= useImm;
			idRegWrite <= regWrite;
			idBranchEq <= branchEq;
			idBranchNe <= branchNe;
		end
	end

	// Payload half
	always_ff @(posedge clk) begin
		idRsData <= rsData;
		idRtData <= rtData;
		idImm <= imm;
		idRs <= rs;
		idRt <= rt;
		idDest <= dest;
		idPcPlus4 <= ifPcPlus4;
	end

endmodule

// File: logic/fetchStage.sv
// Fetch stage holding the program counter, instruction memory and fetch/decode register
`timescale 1ns/1ps

module fetchStage #(
	parameter int imemDepth = 64,
	localparam int idxWidth = $clog2(imemDepth)
) (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          run,
	input  logic                          progWrite,
	input  logic [idxWidth-1:0]           progAddr,
	input  logic [mipsPkg::dataWidth-1:0] progData,
	input  logic                          redirect,
	input  logic [mipsPkg::dataWidth-1:0] redirectTarget,
	output logic                          ifValid,
	output logic [mipsPkg::dataWidth-1:0] ifInstr,
	output logic [mipsPkg::dataWidth-1:0] ifPcPlus4
);

	logic [mipsPkg::dataWidth-1:0] pc;
	logic [mipsPkg::dataWidth-1:0] pcPlus4;
	logic [mipsPkg::dataWidth-1:0] fetchWord;
	logic                          inRange;
	logic [mipsPkg::dataWidth-1:0] imem [imemDepth];

	// Program load, only while the pipeline is idle
	always_ff @(posedge clk) begin
		if (progWrite && !run) begin
			imem[progAddr] <= progData;
		end
	end

	assign pcPlus4 = pc + 32'd4;

	// Word index past the end reads as zero, which decodes as a bubble
	assign inRange = (pc >> 2) < imemDepth;
	assign fetchWord = inRange ? imem[pc[idxWidth+1:2]] : '0;

	// PC and the valid bit of the fetch/decode register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ifValid <= 1'b0;
		end else if (!run) begin
			// Idle, hold at address zero
			pc <= '0;
			ifValid <= 1'b0;
		end else if (redirect) begin
			// Squash the word fetched this cycle
			pc <= redirectTarget;
			ifValid <= 1'b0;
		end else begin
			pc <= pcPlus4;
			ifValid <= 1'b1;
		end
	end

	// Fetched word and its return address
	always_ff @(posedge clk) begin
		ifInstr <= fetchWord;
		ifPcPlus4 <= pcPlus4;
	end

	// Program loading and execution never overlap
	progWhileIdle: assert property (@(posedge clk) disable iff (!rstN)
		progWrite |-> !run);

endmodule

// File: logic/registerFile.sv
// Register file with two combinational reads, write-first bypass and a constant zero register
`timescale 1ns/1ps

module registerFile (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [mipsPkg::regAddrWidth-1:0] rsAddr,
	input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
	input  logic                             writeEnable,
	input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input  logic [mipsPkg::dataWidth-1:0]    writeData,
	output logic [mipsPkg::dataWidth-1:0]    rsData,
	output logic [mipsPkg::dataWidth-1:0]    rtData
);

	logic [mipsPkg::dataWidth-1:0] regs [32];

	// Architectural state starts at zero
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Same-cycle write is visible to the reader
	assign rsData = (rsAddr == '0) ? '0 :
		(writeEnable && writeAddr == rsAddr) ? writeData : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 :
		(writeEnable && writeAddr == rtAddr) ? writeData : regs[rtAddr];

	// Retire never issues a write to register zero
	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		writeEnable |-> writeAddr != '0);

endmodule

// File: logic/mipsPkg.sv
// Shared MIPS definitions for opcodes, function codes, ALU operations and widths
package mipsPkg;

	// Datapath word width
	parameter int dataWidth = 32;

	// Register index width, 32 registers
	parameter int regAddrWidth = 5;

	// Opcode field, bits 31..26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opOri   = 6'h0d
	} opcodeT;

	// Function field of R-type words, bits 5..0
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnNor = 6'h27
	} functT;

	// Operation selected in the execute stage
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluNor = 3'd4
	} aluOpT;

endpackage
